// ==== Bender.yml ====
package:
  name: analog_top

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/analog_pkg.sv
      - hdl/cfg_bus_if.sv
      - hdl/cfg_regs.sv
      - hdl/adc_front.sv
      - hdl/out_limit.sv
      - hdl/dac_front.sv
      - hdl/analog_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/tb_analog_top.sv

// ==== hdl/adc_front.sv ====
// fast adc input stage
// captures the 14 data bits, converts negative-slope code to two's complement
// and optionally swaps in the limited dac samples for digital loopback
`timescale 1ns/1ps
`include "analog_cfg.svh"

module adc_front import analog_pkg::*; (
  input  logic                                adc_clk,
  input  logic                                rst_n_i,
  input  logic [`AN_CH-1:0][`AN_ADC_W-1:0]    adc_dat_i,
  input  logic                                loop_en_i,
  input  sample_t                             loop_dat_i [`AN_CH],
  output sample_t                             adc_o      [`AN_CH]
);

  sample_t adc_q [`AN_CH];  // converted pin samples

  //////////////////////////////////////////////////////////////
  // capture and conversion
  //////////////////////////////////////////////////////////////

  // low two bits reserved on the 16 bit part
  // msb kept, rest inverted for the negative slope
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < `AN_CH; i++)
        adc_q[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < `AN_CH; i++)
        adc_q[i] <= {adc_dat_i[i][`AN_ADC_W-1], ~adc_dat_i[i][`AN_ADC_W-2:`AN_ADC_W-`AN_DW]};
    end
  end

  // loopback mux, no extra stage
  always_comb
  begin
    for (int i = 0; i < `AN_CH; i++)
      adc_o[i] = loop_en_i ? loop_dat_i[i] : adc_q[i];
  end

endmodule

// ==== hdl/analog_cfg.svh ====
// analog front end configuration
// widths, channel count, register map and limit reset values
`ifndef ANALOG_CFG_SVH
`define ANALOG_CFG_SVH

// datapath
`define AN_CH      2   // fast adc / dac channels
`define AN_ADC_W   16  // raw adc pin word, two low bits reserved
`define AN_DW      14  // sample width

// configuration bus
`define AN_CFG_AW  8
`define AN_CFG_DW  32

// register map, byte addresses
`define AN_REG_CTRL  8'h00  // bit 0 digital loopback
`define AN_REG_MAX0  8'h04
`define AN_REG_MIN0  8'h08
`define AN_REG_MAX1  8'h0C
`define AN_REG_MIN1  8'h10

// limits open to the full range out of reset
`define AN_LIM_MAX_RST  14'sh1FFF  // +8191
`define AN_LIM_MIN_RST  14'sh2000  // -8192

`endif

// ==== hdl/analog_pkg.sv ====
// analog front end types
// samples, sums, pin codes, rail flags and config bus fields
`include "analog_cfg.svh"

package analog_pkg;

  // two's complement sample as seen by the rest of the design
  typedef logic signed [`AN_DW-1:0] sample_t;

  // gen + ctl sum, one guard bit for overflow detection
  typedef logic signed [`AN_DW:0]   sum_t;

  // offset negative-slope code on the converter pins
  typedef logic        [`AN_DW-1:0] dac_code_t;

  // limiter status, [1] clamped high, [0] clamped low
  typedef logic        [1:0]        rail_t;

  localparam int RAIL_HI = 1;
  localparam int RAIL_LO = 0;

  // config bus fields
  typedef logic [`AN_CFG_AW-1:0] cfg_addr_t;
  typedef logic [`AN_CFG_DW-1:0] cfg_data_t;

endpackage

// ==== hdl/analog_top.sv ====
// analog front end top level
// two channel adc capture, output sum and limiting, dac coding and the
// configuration register block behind a four-phase bus
`timescale 1ns/1ps
`include "analog_cfg.svh"

module analog_top import analog_pkg::*; (
  input  logic                             adc_clk,
  input  logic                             rst_n_i,
  // fast adc pins
  input  logic [`AN_CH-1:0][`AN_ADC_W-1:0] adc_dat_i,
  // generator and controller samples
  input  sample_t                          gen_dat_i [`AN_CH],
  input  sample_t                          ctl_dat_i [`AN_CH],
  // configuration bus
  input  logic                             cfg_req_i,
  input  logic                             cfg_we_i,
  input  cfg_addr_t                        cfg_addr_i,
  input  cfg_data_t                        cfg_wdata_i,
  output logic                             cfg_ack_o,
  output cfg_data_t                        cfg_rdata_o,
  // sample outputs
  output sample_t                          adc_o     [`AN_CH],  // to scope / pid
  output dac_code_t                        dac_dat_o [`AN_CH],  // dac pins
  output rail_t                            rail_o    [`AN_CH],  // limiter status
  output sample_t                          center_o  [`AN_CH]   // range centers
);

  logic    loop_en;
  sample_t lim_max [`AN_CH];
  sample_t lim_min [`AN_CH];
  sample_t lim     [`AN_CH];  // limited samples, shared by dac and loopback

  //////////////////////////////////////////////////////////////
  // configuration
  //////////////////////////////////////////////////////////////

  cfg_bus_if cfg_bus ();

  // pins act as the bus master
  assign cfg_bus.req   = cfg_req_i;
  assign cfg_bus.we    = cfg_we_i;
  assign cfg_bus.addr  = cfg_addr_i;
  assign cfg_bus.wdata = cfg_wdata_i;
  assign cfg_ack_o     = cfg_bus.ack;
  assign cfg_rdata_o   = cfg_bus.rdata;

  cfg_regs cfg_regs_i (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .bus       (cfg_bus.slave),
    .loop_en_o (loop_en),
    .lim_max_o (lim_max),
    .lim_min_o (lim_min)
  );

  //////////////////////////////////////////////////////////////
  // adc path
  //////////////////////////////////////////////////////////////

  adc_front adc_front_i (
    .adc_clk    (adc_clk),
    .rst_n_i    (rst_n_i),
    .adc_dat_i  (adc_dat_i),
    .loop_en_i  (loop_en),
    .loop_dat_i (lim),        // digital loopback source
    .adc_o      (adc_o)
  );

  //////////////////////////////////////////////////////////////
  // dac path
  //////////////////////////////////////////////////////////////

  // one limiter per channel
  for (genvar ch = 0; ch < `AN_CH; ch++)
  begin : g_lim
    out_limit out_limit_i (
      .adc_clk   (adc_clk),
      .rst_n_i   (rst_n_i),
      .gen_i     (gen_dat_i[ch]),
      .ctl_i     (ctl_dat_i[ch]),
      .lim_max_i (lim_max[ch]),
      .lim_min_i (lim_min[ch]),
      .lim_o     (lim[ch]),
      .rail_o    (rail_o[ch]),
      .center_o  (center_o[ch])
    );
  end

  dac_front dac_front_i (
    .adc_clk   (adc_clk),
    .rst_n_i   (rst_n_i),
    .lim_i     (lim),
    .dac_dat_o (dac_dat_o)   // separate port per channel
  );

endmodule

// ==== hdl/cfg_bus_if.sv ====
// four-phase req/ack configuration bus
// master drives request and write data, slave answers with ack and read data
`timescale 1ns/1ps
`include "analog_cfg.svh"

interface cfg_bus_if;

  logic                  req;    // held until ack seen
  logic                  we;     // 1 write, 0 read
  logic [`AN_CFG_AW-1:0] addr;
  logic [`AN_CFG_DW-1:0] wdata;
  logic                  ack;    // rdata valid while high
  logic [`AN_CFG_DW-1:0] rdata;

  // requester side
  modport master (
    output req, we, addr, wdata,
    input  ack, rdata
  );

  // register block side
  modport slave (
    input  req, we, addr, wdata,
    output ack, rdata
  );

endinterface

// ==== hdl/cfg_regs.sv ====
// configuration registers for the analog front end
// four-phase bus slave holding loopback enable and output limits
`timescale 1ns/1ps
`include "analog_cfg.svh"

module cfg_regs import analog_pkg::*; (
  input  logic       adc_clk,
  input  logic       rst_n_i,
  cfg_bus_if.slave   bus,
  output logic       loop_en_o,
  output sample_t    lim_max_o [`AN_CH],
  output sample_t    lim_min_o [`AN_CH]
);

  typedef enum logic [1:0] {
    ST_IDLE,  // waiting for req
    ST_ACK,   // access done, ack up
    ST_WAIT   // ack held until req drops
  } state_t;

  state_t    state_q;
  logic      loop_q;
  sample_t   max_q [`AN_CH];
  sample_t   min_q [`AN_CH];
  cfg_data_t rdata_q;
  cfg_data_t rd_mux;
  logic      access;

  // sign extend a limit into the bus word
  function automatic cfg_data_t sext(input sample_t s);
    sext = {{(`AN_CFG_DW-`AN_DW){s[`AN_DW-1]}}, s};
  endfunction

  assign access = (state_q == ST_IDLE) && bus.req;  // one access per handshake

  //////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      state_q <= ST_IDLE;
    else
    begin
      case (state_q)
        ST_IDLE: if (bus.req) state_q <= ST_ACK;
        ST_ACK:  state_q <= bus.req ? ST_WAIT : ST_IDLE;
        ST_WAIT: if (!bus.req) state_q <= ST_IDLE;  // ack drops next edge
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign bus.ack   = (state_q != ST_IDLE);
  assign bus.rdata = rdata_q;

  //////////////////////////////////////////////////////////////
  // register file
  //////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      loop_q <= 1'b0;
      for (int i = 0; i < `AN_CH; i++)
      begin
        max_q[i] <= `AN_LIM_MAX_RST;
        min_q[i] <= `AN_LIM_MIN_RST;
      end
    end
    else if (access && bus.we)
    begin
      case (bus.addr)
        `AN_REG_CTRL: loop_q   <= bus.wdata[0];
        `AN_REG_MAX0: max_q[0] <= bus.wdata[`AN_DW-1:0];
        `AN_REG_MIN0: min_q[0] <= bus.wdata[`AN_DW-1:0];
        `AN_REG_MAX1: max_q[1] <= bus.wdata[`AN_DW-1:0];
        `AN_REG_MIN1: min_q[1] <= bus.wdata[`AN_DW-1:0];
        default: ;  // unmapped, dropped
      endcase
    end
  end

  // read mux, unmapped reads as zero
  always_comb
  begin
    case (bus.addr)
      `AN_REG_CTRL: rd_mux = {{(`AN_CFG_DW-1){1'b0}}, loop_q};
      `AN_REG_MAX0: rd_mux = sext(max_q[0]);
      `AN_REG_MIN0: rd_mux = sext(min_q[0]);
      `AN_REG_MAX1: rd_mux = sext(max_q[1]);
      `AN_REG_MIN1: rd_mux = sext(min_q[1]);
      default:      rd_mux = '0;
    endcase
  end

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
      rdata_q <= '0;
    else if (access)
      rdata_q <= bus.we ? '0 : rd_mux;  // writes return nothing
  end

  assign loop_en_o = loop_q;
  assign lim_max_o = max_q;
  assign lim_min_o = min_q;

endmodule

// ==== hdl/dac_front.sv ====
// fast dac output stage
// registers the limited samples in the dac offset negative-slope code
`timescale 1ns/1ps
`include "analog_cfg.svh"

module dac_front import analog_pkg::*; (
  input  logic      adc_clk,
  input  logic      rst_n_i,
  input  sample_t   lim_i     [`AN_CH],
  output dac_code_t dac_dat_o [`AN_CH]
);

  // pin code for a zero sample
  localparam dac_code_t ZERO_CODE = {1'b0, {(`AN_DW-1){1'b1}}};

  dac_code_t dac_q [`AN_CH];

  // msb kept, rest inverted
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < `AN_CH; i++)
        dac_q[i] <= ZERO_CODE;  // dac idles mid scale
    end
    else
    begin
      for (int i = 0; i < `AN_CH; i++)
        dac_q[i] <= {lim_i[i][`AN_DW-1], ~lim_i[i][`AN_DW-2:0]};
    end
  end

  assign dac_dat_o = dac_q;

endmodule

// ==== hdl/out_limit.sv ====
// output limiter for one channel
// adds generator and controller, saturates to 14 bits, clamps to the
// programmed range and reports rail hits and the range center
`timescale 1ns/1ps
`include "analog_cfg.svh"

module out_limit import analog_pkg::*; (
  input  logic    adc_clk,
  input  logic    rst_n_i,
  input  sample_t gen_i,      // generator sample
  input  sample_t ctl_i,      // controller sample
  input  sample_t lim_max_i,
  input  sample_t lim_min_i,
  output sample_t lim_o,
  output rail_t   rail_o,
  output sample_t center_o
);

  sum_t    sum;     // one guard bit
  sample_t sat;     // after saturation
  sample_t clamp;
  rail_t   rail;
  sum_t    rng;     // max + min
  sample_t lim_q;
  rail_t   rail_q;
  sample_t center_q;

  //////////////////////////////////////////////////////////////
  // sum and saturation
  //////////////////////////////////////////////////////////////

  assign sum = gen_i + ctl_i;  // both sign extended to 15 bits

  // guard and msb disagree -> overflow, pick the extreme by sign
  always_comb
  begin
    if (sum[`AN_DW] != sum[`AN_DW-1])
      sat = {sum[`AN_DW], {(`AN_DW-1){~sum[`AN_DW]}}};
    else
      sat = sum[`AN_DW-1:0];
  end

  // programmable clamp, max checked first
  always_comb
  begin
    clamp = sat;
    rail  = '0;
    if (sat > lim_max_i)
    begin
      clamp         = lim_max_i;
      rail[RAIL_HI] = 1'b1;
    end
    else if (sat < lim_min_i)
    begin
      clamp         = lim_min_i;
      rail[RAIL_LO] = 1'b1;
    end
  end

  // half sum, floor by dropping the lsb of the signed sum
  assign rng = lim_max_i + lim_min_i;

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      lim_q    <= '0;
      rail_q   <= '0;
      center_q <= '0;
    end
    else
    begin
      lim_q    <= clamp;
      rail_q   <= rail;
      center_q <= rng[`AN_DW:1];
    end
  end

  assign lim_o    = lim_q;
  assign rail_o   = rail_q;
  assign center_o = center_q;

endmodule

// ==== src.f ====
+incdir+hdl
hdl/analog_pkg.sv
hdl/cfg_bus_if.sv
hdl/cfg_regs.sv
hdl/adc_front.sv
hdl/out_limit.sv
hdl/dac_front.sv
hdl/analog_top.sv
tb/tb_analog_top.sv

// ==== tb/tb_analog_top.sv ====
// testbench for the analog front end top level
// table of register setups and samples, checked against a reference model
`timescale 1ns/1ps
`include "analog_cfg.svh"

module tb_analog_top import analog_pkg::*; ();

  localparam int BUS_TMO = 20;  // cycles per handshake phase

  typedef struct {
    string       name;
    bit          loop;
    int          max;
    int          min;
    int          gen;
    int          ctl;
    logic [15:0] adc;  // channel 1 gets the inverted word
  } vec_t;

  logic                             adc_clk;
  logic                             rst_n;
  logic [`AN_CH-1:0][`AN_ADC_W-1:0] adc_dat;
  sample_t                          gen_dat [`AN_CH];
  sample_t                          ctl_dat [`AN_CH];
  logic                             cfg_req;
  logic                             cfg_we;
  cfg_addr_t                        cfg_addr;
  cfg_data_t                        cfg_wdata;
  logic                             cfg_ack;
  cfg_data_t                        cfg_rdata;
  sample_t                          adc_out [`AN_CH];
  dac_code_t                        dac_dat [`AN_CH];
  rail_t                            rail    [`AN_CH];
  sample_t                          center  [`AN_CH];

  vec_t tbl[$];
  int   errors;
  int   tests;
  int   failed;

  analog_top analog_top_i (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n),
    .adc_dat_i   (adc_dat),
    .gen_dat_i   (gen_dat),
    .ctl_dat_i   (ctl_dat),
    .cfg_req_i   (cfg_req),
    .cfg_we_i    (cfg_we),
    .cfg_addr_i  (cfg_addr),
    .cfg_wdata_i (cfg_wdata),
    .cfg_ack_o   (cfg_ack),
    .cfg_rdata_o (cfg_rdata),
    .adc_o       (adc_out),
    .dac_dat_o   (dac_dat),
    .rail_o      (rail),
    .center_o    (center)
  );

  always #50 adc_clk = ~adc_clk;  // 100 ns period

  //////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////

  // negative slope code where 0 maps to +8191
  function automatic int adc_ref(input logic [15:0] w);
    int code;
    code = w[15:2];  // reserved bits dropped
    return 8191 - code;
  endfunction

  function automatic int saturate(input int s);
    if (s > 8191)
      return 8191;
    if (s < -8192)
      return -8192;
    return s;
  endfunction

  function automatic int limit_ref(input int s, input int max, input int min);
    int v;
    v = saturate(s);
    if (v > max)
      return max;
    if (v < min)
      return min;
    return v;
  endfunction

  function automatic int rail_ref(input int s, input int max, input int min);
    int v;
    v = saturate(s);
    if (v > max)
      return 2;  // high rail
    if (v < min)
      return 1;
    return 0;
  endfunction

  //////////////////////////////////////////////////////////////
  // checking and bus driver
  //////////////////////////////////////////////////////////////

  task automatic compare(input string tname, input string what, input int exp, input int act);
    if (exp != act)
    begin
      $display("mismatch %s %s: expected %0d actual %0d", tname, what, exp, act);
      errors++;
    end
  endtask

  // one full four-phase access
  task automatic bus_access(input logic we, input cfg_addr_t addr, input cfg_data_t wdata,
                            output cfg_data_t rdata);
    int n;
    @(posedge adc_clk);
    #1;
    cfg_req   = 1'b1;
    cfg_we    = we;
    cfg_addr  = addr;
    cfg_wdata = wdata;
    n = 0;
    while (!cfg_ack && n < BUS_TMO)
    begin
      @(posedge adc_clk);
      #1;
      n++;
    end
    if (!cfg_ack)
    begin
      $display("bus timeout: no ack for access to address %h", addr);
      errors++;
    end
    rdata   = cfg_rdata;  // valid while ack high
    cfg_req = 1'b0;
    n = 0;
    while (cfg_ack && n < BUS_TMO)
    begin
      @(posedge adc_clk);
      #1;
      n++;
    end
    if (cfg_ack)
    begin
      $display("bus timeout: ack stuck high after access to address %h", addr);
      errors++;
    end
  endtask

  task automatic finish_test(input string tname, input int err0);
    tests++;
    if (errors > err0)
    begin
      failed++;
      $display("test %s: FAIL", tname);
    end
    else
      $display("test %s: ok", tname);
  endtask

  task automatic run_vec(input vec_t v);
    cfg_data_t   rd;
    int          err0;
    int          exp_l;
    logic [15:0] w;
    err0 = errors;
    bus_access(1'b1, `AN_REG_CTRL, {31'b0, v.loop}, rd);
    bus_access(1'b1, `AN_REG_MAX0, cfg_data_t'(v.max), rd);
    bus_access(1'b1, `AN_REG_MIN0, cfg_data_t'(v.min), rd);
    bus_access(1'b1, `AN_REG_MAX1, cfg_data_t'(v.max), rd);
    bus_access(1'b1, `AN_REG_MIN1, cfg_data_t'(v.min), rd);
    bus_access(1'b0, `AN_REG_MAX0, '0, rd);
    compare(v.name, "max0 readback", v.max, int'(rd));
    bus_access(1'b0, `AN_REG_MIN1, '0, rd);
    compare(v.name, "min1 readback", v.min, int'(rd));
    @(posedge adc_clk);
    #1;
    adc_dat[0] = v.adc;
    adc_dat[1] = ~v.adc;
    gen_dat[0] = v.gen;
    ctl_dat[0] = v.ctl;
    gen_dat[1] = v.ctl;  // same sum from swapped sources
    ctl_dat[1] = v.gen;
    @(posedge adc_clk);
    @(negedge adc_clk);
    exp_l = limit_ref(v.gen + v.ctl, v.max, v.min);
    for (int ch = 0; ch < `AN_CH; ch++)
    begin
      w = (ch == 0) ? v.adc : ~v.adc;
      compare(v.name, "adc_o", v.loop ? exp_l : adc_ref(w), int'(adc_out[ch]));
      compare(v.name, "rail_o", rail_ref(v.gen + v.ctl, v.max, v.min), int'(rail[ch]));
      compare(v.name, "center_o", (v.max + v.min) >>> 1, int'(center[ch]));
    end
    @(posedge adc_clk);
    @(negedge adc_clk);
    for (int ch = 0; ch < `AN_CH; ch++)
      compare(v.name, "dac_dat_o", 8191 - exp_l, int'(dac_dat[ch]));
    finish_test(v.name, err0);
  endtask

  //////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////

  initial
  begin
    cfg_data_t rd;
    int        err0;
    int        lo;
    int        hi;
    adc_clk   = 1'b0;
    rst_n     = 1'b0;
    adc_dat   = '0;
    cfg_req   = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    for (int ch = 0; ch < `AN_CH; ch++)
    begin
      gen_dat[ch] = '0;
      ctl_dat[ch] = '0;
    end
    errors = 0;
    tests  = 0;
    failed = 0;
    void'($urandom(32'hd7cf49bc));

    // name, loop, max, min, gen, ctl, adc pins
    tbl.push_back('{"adc_zero",   1'b0,  8191, -8192,     0,     0, 16'h0000});
    tbl.push_back('{"adc_full",   1'b0,  8191, -8192,     0,     0, 16'hFFFC});
    tbl.push_back('{"adc_mid",    1'b0,  8191, -8192,     0,     0, 16'h8000});
    tbl.push_back('{"sat_pos",    1'b0,  8191, -8192,  6000,  5000, 16'h1234});
    tbl.push_back('{"sat_neg",    1'b0,  8191, -8192, -6000, -5000, 16'h4321});
    tbl.push_back('{"sum_in",     1'b0,  8191, -8192,  1234,  -200, 16'hA5A4});
    tbl.push_back('{"clamp_hi",   1'b0,  1000,  -500,   900,   300, 16'h0F00});
    tbl.push_back('{"clamp_lo",   1'b0,  1000,  -500,  -400,  -300, 16'hF0F0});
    tbl.push_back('{"clamp_in",   1'b0,  1000,  -500,   100,    50, 16'h5554});
    tbl.push_back('{"center_odd", 1'b0,  1001, -2000,     0,     0, 16'h0004});
    tbl.push_back('{"loop_on",    1'b1,  3000, -3000,  2500,  1000, 16'h1234});
    tbl.push_back('{"loop_off",   1'b0,  3000, -3000,  2500,  1000, 16'h1234});
    for (int k = 0; k < 6; k++)
    begin
      hi = $urandom_range(8191, 0);
      lo = -int'($urandom_range(8192, 0));
      tbl.push_back('{$sformatf("rand_%0d", k), 1'($urandom_range(1, 0)), hi, lo,
                      int'($urandom_range(16383, 0)) - 8192,
                      int'($urandom_range(16383, 0)) - 8192,
                      16'($urandom)});
    end

    // reset state sampled while reset is held
    @(negedge adc_clk);
    err0 = errors;
    compare("reset", "cfg_ack_o", 0, int'(cfg_ack));
    for (int ch = 0; ch < `AN_CH; ch++)
    begin
      compare("reset", "dac_dat_o", 8191, int'(dac_dat[ch]));
      compare("reset", "adc_o", 0, int'(adc_out[ch]));
      compare("reset", "rail_o", 0, int'(rail[ch]));
      compare("reset", "center_o", 0, int'(center[ch]));
    end
    finish_test("reset", err0);
    repeat (2) @(posedge adc_clk);
    #1;
    rst_n = 1'b1;

    foreach (tbl[i])
      run_vec(tbl[i]);

    // register map holes and control readback
    // ctrl cleared first so a stray write to the hole would show up in it
    err0 = errors;
    bus_access(1'b1, `AN_REG_CTRL, 32'h0, rd);
    bus_access(1'b1, 8'h20, 32'hDEADBEEF, rd);
    bus_access(1'b0, 8'h20, '0, rd);
    compare("unmapped", "read 0x20", 0, int'(rd));
    bus_access(1'b0, `AN_REG_CTRL, '0, rd);
    compare("unmapped", "ctrl after hole write", 0, int'(rd));
    bus_access(1'b1, `AN_REG_CTRL, 32'h1, rd);
    bus_access(1'b0, `AN_REG_CTRL, '0, rd);
    compare("unmapped", "ctrl readback", 1, int'(rd));
    finish_test("unmapped", err0);

    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule
